// ==== test/vector_core_patterns.txt ====
# M addr word | T name | V instr rs1 vl | A instr rs1 | L instr rs1 addr size
# S or P (P issues the next line during the stall) instr rs1 addr size then vl words, vl/size decimal
M 00001000 00000011
M 00001004 80000000
M 00001008 12345678
M 0000100C FFFFFFFF
M 00002000 00000022
M 00002004 00000001
M 00002008 0F0F0F0F
M 0000200C 00000001
M 00003000 A5A5A5A5
M 00003004 00000100
M 00003008 DEADBEEF
M 0000300C 00000003
T vl_clamp
V 0102F057 00000007 4
L 02056087 00001000 00001000 16
T load_store
S 020560A7 00004000 00004000 16 00000011 80000000 12345678 FFFFFFFF
T opivv
L 02056107 00002000 00002000 16
A 02110257 00000000
S 02056227 00004100 00004100 16 00000033 80000001 21436587 00000000
A 0A1102D7 00000000
S 020562A7 00004200 00004200 16 FFFFFFEF 7FFFFFFF 03254769 FFFFFFFE
A 26110357 00000000
S 02056327 00004300 00004300 16 00000000 00000000 02040608 00000001
A 2A1103D7 00000000
S 020563A7 00004400 00004400 16 00000033 80000001 1F3F5F7F FFFFFFFF
A 2E110457 00000000
S 02056427 00004500 00004500 16 00000033 80000001 1D3B5977 FFFFFFFE
T opivx
A 021544D7 00000100
S 020564A7 00004600 00004600 16 00000111 80000100 12345778 000000FF
A 2E154557 FFFF0000
S 02056527 00004700 00004700 16 FFFF0011 7FFF0000 EDCB5678 0000FFFF
A 0A1545D7 00000010
S 020565A7 00004800 00004800 16 00000001 7FFFFFF0 12345668 FFFFFFEF
T tail_undisturbed
L 02056187 00003000 00003000 16
V 0102F057 00000002 2
A 023081D7 00000000
V 0102F057 00000004 4
S 020561A7 00004900 00004900 16 A5A5A5B6 80000100 DEADBEEF 00000003
T stall_hold
P 020560A7 00005000 00005000 16 00000011 80000000 12345678 FFFFFFFF
S 02056227 00005100 00005100 16 00000033 80000001 21436587 00000000
T empty_transfer
V 0102F057 00000000 0
L 02056087 00006000 00006000 0
S 020560A7 00006100 00006100 0
V 0102F057 00000004 4
S 020560A7 00006200 00006200 16 00000011 80000000 12345678 FFFFFFFF

// ==== vlog.f ====
logic/vcore_pkg.sv
logic/vector_ctrl.sv
logic/vector_lanes.sv
logic/vector_mem_unit.sv
logic/vector_core.sv
test/vector_core_tb.sv

// ==== Bender.yml ====
package:
  name: vector_core

sources:
  - files:
      - logic/vcore_pkg.sv
      - logic/vector_ctrl.sv
      - logic/vector_lanes.sv
      - logic/vector_mem_unit.sv
      - logic/vector_core.sv
  - target: test
    files:
      - test/vector_core_tb.sv

// ==== test/vector_core_tb.sv ====
`timescale 1ns/1ps

module vector_core_tb;
   import vcore_pkg::*;

   localparam int TIMEOUT_CYCLES = 200;

   logic       clk;
   logic       rstn;
   elem_t      vector_instr_i;
   logic       vector_instr_vld_i;
   elem_t      rs1_i;
   elem_t      rs2_i;
   logic       vector_stall_o;
   addr_t      ctrl_raddr_offset_o;
   xfer_size_t ctrl_rxfer_size_o;
   logic       ctrl_rstart_o;
   logic       ctrl_rdone_i;
   elem_t      rd_tdata_i;
   logic       rd_tvalid_i;
   logic       rd_tready_o;
   logic       rd_tlast_i;
   addr_t      ctrl_waddr_offset_o;
   xfer_size_t ctrl_wxfer_size_o;
   logic       ctrl_wstart_o;
   logic       ctrl_wdone_i;
   elem_t      wr_tdata_o;
   logic       wr_tvalid_o;
   logic       wr_tready_i;

   elem_t           mem [addr_t];  // Responder memory keyed by byte address
   addr_t           exp_addr_q [$];
   xfer_size_t      exp_size_q [$];
   int              exp_beats_q [$];
   logic            exp_is_st_q [$];
   elem_t           exp_word_q [$];  // Stored words of all pending stores
   logic            xfer_open;
   int              start_cnt;
   int              err_cnt;
   int              check_cnt;
   int              test_cnt;
   int              test_fail_cnt;
   int              test_err_base;
   logic [8*32-1:0] test_name;

   vector_core UUT (.*);

   always #10 clk = ~clk;

   task automatic abort_timeout(input string what);
      $display("TIMEOUT at %0t ns: %0s", $time, what);
      $display("Simulation finished: FAIL");
      $finish;
   endtask

   task automatic report_error(input string what);
      $display("ERROR at %0t ns: %0s", $time, what);
      err_cnt++;
   endtask

   task automatic check_elem(input string name, input elem_t got, input elem_t exp);
      check_cnt++;
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t ns: %0s got %h expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      check_cnt++;
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t ns: %0s got %h expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_size(input string name, input xfer_size_t got, input xfer_size_t exp);
      check_cnt++;
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t ns: %0s got %0d expected %0d", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      check_cnt++;
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t ns: %0s got %b expected %b", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic finish_test();
      int errs;
      errs = err_cnt - test_err_base;
      test_cnt++;
      if (errs == 0)
         $display("test %0d %0s: passed", test_cnt, test_name);
      else
      begin
         $display("test %0d %0s: failed with %0d errors", test_cnt, test_name, errs);
         test_fail_cnt++;
      end
      test_err_base = err_cnt;
   endtask

   task automatic wait_stall_low();
      int cycles;
      cycles = 0;
      while (vector_stall_o)
      begin
         @(posedge clk);
         #2;
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
            abort_timeout("vector_stall_o stayed high");
      end
   endtask

   // Holds the instruction on the port until the core accepts it
   task automatic issue_instr(input elem_t instr, input elem_t rs1, input logic is_mem,
                              input logic wait_end);
      vector_instr_i     = instr;
      rs1_i              = rs1;
      vector_instr_vld_i = 1'b1;
      wait_stall_low();
      @(posedge clk);  // Accepted here
      #2;
      vector_instr_vld_i = 1'b0;
      if (is_mem)
      begin
         check_flag("vector_stall_o", vector_stall_o, 1'b1);
         if (wait_end)
            wait_stall_low();
      end
   endtask

   task automatic pulse_done(input logic is_st);
      repeat (1 + ($urandom % 3))
      begin
         @(posedge clk);
         #2;
      end
      if (is_st)
         ctrl_wdone_i = 1'b1;
      else
         ctrl_rdone_i = 1'b1;
      xfer_open = 1'b0;
      @(posedge clk);
      #2;
      ctrl_wdone_i = 1'b0;
      ctrl_rdone_i = 1'b0;
   endtask

   task automatic run_load();
      addr_t base;
      addr_t a;
      int    beats;
      int    k;
      int    cycles;
      if ((exp_is_st_q.size() == 0) || exp_is_st_q[0])
      begin
         report_error("a load started where none was expected");
         base  = ctrl_raddr_offset_o;
         beats = ctrl_rxfer_size_o / ELEM_BYTES;
      end
      else
      begin
         exp_is_st_q.delete(0);
         base  = exp_addr_q.pop_front();
         beats = exp_beats_q.pop_front();
         check_addr("ctrl_raddr_offset_o", ctrl_raddr_offset_o, base);
         check_size("ctrl_rxfer_size_o", ctrl_rxfer_size_o, exp_size_q.pop_front());
      end
      k = 0;
      while (k < beats)
      begin
         repeat ($urandom % 3)
         begin
            rd_tvalid_i = 1'b0;  // Gap in the stream
            @(posedge clk);
            #2;
         end
         a           = base + addr_t'(k * ELEM_BYTES);
         rd_tvalid_i = 1'b1;
         rd_tlast_i  = (k == beats - 1);
         if (mem.exists(a))
            rd_tdata_i = mem[a];
         else
         begin
            report_error($sformatf("load read the unloaded address %h", a));
            rd_tdata_i = '0;
         end
         cycles = 0;
         while (!rd_tready_o)
         begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
               abort_timeout("rd_tready_o never rose");
         end
         @(posedge clk);
         #2;
         k++;
      end
      rd_tvalid_i = 1'b0;
      rd_tlast_i  = 1'b0;
      pulse_done(1'b0);
   endtask

   task automatic run_store();
      addr_t base;
      elem_t got;
      int    beats;
      int    k;
      int    cycles;
      logic  expected;
      expected = (exp_is_st_q.size() != 0) && exp_is_st_q[0];
      if (!expected)
      begin
         report_error("a store started where none was expected");
         base  = ctrl_waddr_offset_o;
         beats = ctrl_wxfer_size_o / ELEM_BYTES;
      end
      else
      begin
         exp_is_st_q.delete(0);
         base  = exp_addr_q.pop_front();
         beats = exp_beats_q.pop_front();
         check_addr("ctrl_waddr_offset_o", ctrl_waddr_offset_o, base);
         check_size("ctrl_wxfer_size_o", ctrl_wxfer_size_o, exp_size_q.pop_front());
      end
      k      = 0;
      cycles = 0;
      while (k < beats)
      begin
         wr_tready_i = (($urandom % 4) != 0);  // Random ready drops
         if (wr_tvalid_o && wr_tready_i)
         begin
            got = wr_tdata_o;
            if (expected)
               check_elem($sformatf("wr_tdata_o[%0d]", k), got, exp_word_q.pop_front());
            mem[base + addr_t'(k * ELEM_BYTES)] = got;
            k++;
         end
         @(posedge clk);
         #2;
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
            abort_timeout("store stream stopped before its last beat");
      end
      wr_tready_i = 1'b0;
      check_flag("wr_tvalid_o", wr_tvalid_o, 1'b0);  // No beat beyond vl
      pulse_done(1'b1);
   endtask

   // Memory responder
   initial
   begin : responder
      forever
      begin
         @(posedge clk);
         #2;
         if (rstn && ctrl_rstart_o)
            run_load();
         else if (rstn && ctrl_wstart_o)
            run_store();
      end
   end

   // A new start must wait for the previous done
   always @(negedge clk)
   begin
      if (rstn && (ctrl_rstart_o || ctrl_wstart_o))
      begin
         if (xfer_open)
            report_error("a transfer started before the previous one was done");
         xfer_open = 1'b1;
         start_cnt++;
      end
   end

   initial
   begin : main
      int              fd;
      int              rc;
      byte             tag;
      elem_t           instr;
      elem_t           rs1;
      elem_t           w;
      addr_t           a;
      int              size;
      int              cur_vl;
      int              mem_cnt;
      int              cycles;
      logic [8*128-1:0] line_buf;
      clk                = 1'b0;
      rstn               = 1'b0;
      vector_instr_i     = '0;
      vector_instr_vld_i = 1'b0;
      rs1_i              = '0;
      rs2_i              = '0;
      ctrl_rdone_i       = 1'b0;
      rd_tdata_i         = '0;
      rd_tvalid_i        = 1'b0;
      rd_tlast_i         = 1'b0;
      ctrl_wdone_i       = 1'b0;
      wr_tready_i        = 1'b0;
      xfer_open          = 1'b0;
      start_cnt          = 0;
      err_cnt            = 0;
      check_cnt          = 0;
      test_cnt           = 0;
      test_fail_cnt      = 0;
      test_err_base      = 0;
      test_name          = "reset_state";
      cur_vl             = 0;
      mem_cnt            = 0;
      rc                 = $urandom(18);
      repeat (2) @(posedge clk);
      #2;
      rstn = 1'b1;
      check_flag("vector_stall_o", vector_stall_o, 1'b0);
      check_flag("ctrl_rstart_o", ctrl_rstart_o, 1'b0);
      check_flag("ctrl_wstart_o", ctrl_wstart_o, 1'b0);
      check_flag("rd_tready_o", rd_tready_o, 1'b0);
      check_flag("wr_tvalid_o", wr_tvalid_o, 1'b0);

      fd = $fopen("test/vector_core_patterns.txt", "r");
      if (fd == 0)
         report_error("the pattern file could not be opened");
      else
      begin
         while ($fscanf(fd, " %c", tag) == 1)
         begin
            case (tag)
               "#": rc = $fgets(line_buf, fd);
               "T":
               begin
                  finish_test();
                  rc = $fscanf(fd, "%s", test_name);
               end
               "M":
               begin
                  rc     = $fscanf(fd, "%h %h", a, w);
                  mem[a] = w;
               end
               "V":
               begin
                  rc = $fscanf(fd, "%h %h %d", instr, rs1, cur_vl);  // vl expected after clamp
                  issue_instr(instr, rs1, 1'b0, 1'b0);
               end
               "A":
               begin
                  rc = $fscanf(fd, "%h %h", instr, rs1);
                  issue_instr(instr, rs1, 1'b0, 1'b0);
               end
               "L", "S", "P":
               begin
                  rc = $fscanf(fd, "%h %h %h %d", instr, rs1, a, size);
                  exp_is_st_q.push_back(tag != "L");
                  exp_addr_q.push_back(a);
                  exp_size_q.push_back(xfer_size_t'(size));
                  exp_beats_q.push_back(cur_vl);
                  if (tag != "L")
                     repeat (cur_vl)
                     begin
                        rc = $fscanf(fd, "%h", w);
                        exp_word_q.push_back(w);
                     end
                  mem_cnt++;
                  issue_instr(instr, rs1, 1'b1, tag != "P");  // P leaves the stall running
               end
               default: report_error($sformatf("unknown pattern tag %c", tag));
            endcase
         end
         $fclose(fd);
      end

      wait_stall_low();
      cycles = 0;
      while (xfer_open || (exp_addr_q.size() != 0))
      begin
         @(posedge clk);
         #2;
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
            abort_timeout("expected transfers never completed");
      end
      if (start_cnt != mem_cnt)
         report_error($sformatf("%0d transfers started for %0d memory instructions",
                                start_cnt, mem_cnt));
      finish_test();
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_cnt, test_fail_cnt, check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== logic/vector_core.sv ====
`timescale 1ns/1ps

module vector_core
  (
   input  logic                  clk,
   input  logic                  rstn,
   input  vcore_pkg::elem_t      vector_instr_i,
   input  logic                  vector_instr_vld_i,
   input  vcore_pkg::elem_t      rs1_i,
   input  vcore_pkg::elem_t      rs2_i,
   output logic                  vector_stall_o,
   output vcore_pkg::addr_t      ctrl_raddr_offset_o,
   output vcore_pkg::xfer_size_t ctrl_rxfer_size_o,
   output logic                  ctrl_rstart_o,
   input  logic                  ctrl_rdone_i,
   input  vcore_pkg::elem_t      rd_tdata_i,
   input  logic                  rd_tvalid_i,
   output logic                  rd_tready_o,
   input  logic                  rd_tlast_i,
   output vcore_pkg::addr_t      ctrl_waddr_offset_o,
   output vcore_pkg::xfer_size_t ctrl_wxfer_size_o,
   output logic                  ctrl_wstart_o,
   input  logic                  ctrl_wdone_i,
   output vcore_pkg::elem_t      wr_tdata_o,
   output logic                  wr_tvalid_o,
   input  logic                  wr_tready_i
   );
   import vcore_pkg::*;

   logic      mem_ld_go;
   logic      mem_st_go;
   logic      mem_done;
   addr_t     mem_base;
   vl_t       vl;
   logic      alu_we;
   alu_op_e   alu_op;
   vreg_idx_t vd;
   vreg_idx_t vs1;
   vreg_idx_t vs2;
   elem_t     scalar;
   logic      use_scalar;
   logic      ld_we;
   elem_idx_t ld_idx;
   elem_t     ld_data;
   elem_idx_t st_idx;
   elem_t     st_data;

   // Scalar side and clocking connect by name
   vector_ctrl u_ctrl
     (
      .*,
      .mem_done_i   (mem_done),
      .mem_ld_go_o  (mem_ld_go),
      .mem_st_go_o  (mem_st_go),
      .mem_base_o   (mem_base),
      .vl_o         (vl),
      .alu_we_o     (alu_we),
      .alu_op_o     (alu_op),
      .vd_o         (vd),
      .vs1_o        (vs1),
      .vs2_o        (vs2),
      .scalar_o     (scalar),
      .use_scalar_o (use_scalar)
      );

   vector_lanes u_lanes
     (
      .clk          (clk),
      .alu_we_i     (alu_we),
      .alu_op_i     (alu_op),
      .vd_i         (vd),
      .vs1_i        (vs1),
      .vs2_i        (vs2),
      .scalar_i     (scalar),
      .use_scalar_i (use_scalar),
      .vl_i         (vl),
      .ld_we_i      (ld_we),
      .ld_idx_i     (ld_idx),
      .ld_data_i    (ld_data),
      .st_idx_i     (st_idx),
      .st_data_o    (st_data)
      );

   // External control channel and streams connect by name
   vector_mem_unit u_mem
     (
      .*,
      .ld_go_i      (mem_ld_go),
      .st_go_i      (mem_st_go),
      .base_i       (mem_base),
      .vl_i         (vl),
      .done_o       (mem_done),
      .ld_we_o      (ld_we),
      .ld_idx_o     (ld_idx),
      .ld_data_o    (ld_data),
      .st_idx_o     (st_idx),
      .st_data_i    (st_data)
      );

endmodule

// ==== logic/vector_mem_unit.sv ====
`timescale 1ns/1ps

module vector_mem_unit
  (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  ld_go_i,
   input  logic                  st_go_i,
   input  vcore_pkg::addr_t      base_i,
   input  vcore_pkg::vl_t        vl_i,
   output logic                  done_o,
   output vcore_pkg::addr_t      ctrl_raddr_offset_o,
   output vcore_pkg::xfer_size_t ctrl_rxfer_size_o,
   output logic                  ctrl_rstart_o,
   input  logic                  ctrl_rdone_i,
   input  vcore_pkg::elem_t      rd_tdata_i,
   input  logic                  rd_tvalid_i,
   output logic                  rd_tready_o,
   input  logic                  rd_tlast_i,
   output vcore_pkg::addr_t      ctrl_waddr_offset_o,
   output vcore_pkg::xfer_size_t ctrl_wxfer_size_o,
   output logic                  ctrl_wstart_o,
   input  logic                  ctrl_wdone_i,
   output vcore_pkg::elem_t      wr_tdata_o,
   output logic                  wr_tvalid_o,
   input  logic                  wr_tready_i,
   output logic                  ld_we_o,
   output vcore_pkg::elem_idx_t  ld_idx_o,
   output vcore_pkg::elem_t      ld_data_o,
   output vcore_pkg::elem_idx_t  st_idx_o,
   input  vcore_pkg::elem_t      st_data_i
   );
   import vcore_pkg::*;

   mem_state_e state;
   logic       is_st;
   addr_t      addr_q;
   xfer_size_t size_q;
   elem_idx_t  beat_cnt;
   logic       rd_beat;
   logic       wr_beat;
   logic       stream_end;
   logic       xfer_done;

   assign rd_tready_o = (state == MEM_STREAM) && !is_st;
   assign wr_tvalid_o = (state == MEM_STREAM) && is_st;
   assign rd_beat     = rd_tvalid_i && rd_tready_o;
   assign wr_beat     = wr_tvalid_o && wr_tready_i;

   // Loads end on tlast, stores after vl beats
   assign stream_end = is_st ? (wr_beat && ((vl_t'(beat_cnt) + vl_t'(1)) == vl_i))
                             : (rd_beat && rd_tlast_i);
   assign xfer_done  = is_st ? ctrl_wdone_i : ctrl_rdone_i;

   assign ctrl_rstart_o       = (state == MEM_START) && !is_st;
   assign ctrl_wstart_o       = (state == MEM_START) && is_st;
   assign ctrl_raddr_offset_o = addr_q;
   assign ctrl_waddr_offset_o = addr_q;
   assign ctrl_rxfer_size_o   = size_q;
   assign ctrl_wxfer_size_o   = size_q;

   assign ld_we_o    = rd_beat;
   assign ld_idx_o   = beat_cnt;
   assign ld_data_o  = rd_tdata_i;
   assign st_idx_o   = beat_cnt;
   assign wr_tdata_o = st_data_i;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         state    <= MEM_IDLE;
         is_st    <= 1'b0;
         beat_cnt <= '0;
         done_o   <= 1'b0;
      end
      else
      begin
         done_o <= 1'b0;
         case (state)
            MEM_IDLE:
               if (ld_go_i || st_go_i)
               begin
                  state    <= MEM_START;
                  is_st    <= st_go_i;
                  beat_cnt <= '0;
               end
            MEM_START:
               state <= (vl_i == '0) ? MEM_WAIT : MEM_STREAM;  // Empty transfer skips beats
            MEM_STREAM:
            begin
               if (rd_beat || wr_beat)
                  beat_cnt <= beat_cnt + 1'b1;
               if (stream_end)
                  state <= MEM_WAIT;
            end
            MEM_WAIT:
               if (xfer_done)
               begin
                  state  <= MEM_IDLE;
                  done_o <= 1'b1;
               end
            default:
               state <= MEM_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if ((state == MEM_IDLE) && (ld_go_i || st_go_i))
      begin
         addr_q <= base_i;
         size_q <= xfer_size_t'(vl_i) * xfer_size_t'(ELEM_BYTES);
      end
   end

endmodule

// ==== logic/vector_lanes.sv ====
`timescale 1ns/1ps

module vector_lanes
  (
   input  logic                 clk,
   input  logic                 alu_we_i,
   input  vcore_pkg::alu_op_e   alu_op_i,
   input  vcore_pkg::vreg_idx_t vd_i,
   input  vcore_pkg::vreg_idx_t vs1_i,
   input  vcore_pkg::vreg_idx_t vs2_i,
   input  vcore_pkg::elem_t     scalar_i,
   input  logic                 use_scalar_i,
   input  vcore_pkg::vl_t       vl_i,
   input  logic                 ld_we_i,
   input  vcore_pkg::elem_idx_t ld_idx_i,
   input  vcore_pkg::elem_t     ld_data_i,
   input  vcore_pkg::elem_idx_t st_idx_i,
   output vcore_pkg::elem_t     st_data_o
   );
   import vcore_pkg::*;

   elem_t st_word [LANE_NUM];  // Element of vd from each lane

   for (genvar k = 0; k < LANE_NUM; k++)
   begin : g_lane
      elem_t slice [VREG_NUM];  // Element k of every register
      elem_t op_a;
      elem_t op_b;
      elem_t res;
      logic  lane_act;

      assign op_a     = slice[vs2_i];
      assign op_b     = use_scalar_i ? scalar_i : slice[vs1_i];
      assign lane_act = (vl_t'(k) < vl_i);  // Tail stays undisturbed

      always_comb
      begin
         case (alu_op_i)
            ALU_ADD: res = op_a + op_b;
            ALU_SUB: res = op_a - op_b;  // vs2 minus vs1 or rs1
            ALU_AND: res = op_a & op_b;
            ALU_OR:  res = op_a | op_b;
            ALU_XOR: res = op_a ^ op_b;
            default: res = op_a;
         endcase
      end

      always_ff @(posedge clk)
      begin
         if (alu_we_i && lane_act)
            slice[vd_i] <= res;
         else if (ld_we_i && (ld_idx_i == elem_idx_t'(k)))
            slice[vd_i] <= ld_data_i;  // Beat k lands in lane k
      end

      assign st_word[k] = slice[vd_i];
   end

   // Store stream walks the lanes in element order
   assign st_data_o = st_word[st_idx_i];

endmodule

// ==== logic/vector_ctrl.sv ====
`timescale 1ns/1ps

module vector_ctrl
  (
   input  logic                 clk,
   input  logic                 rstn,
   input  vcore_pkg::elem_t     vector_instr_i,
   input  logic                 vector_instr_vld_i,
   input  vcore_pkg::elem_t     rs1_i,
   output logic                 vector_stall_o,
   input  logic                 mem_done_i,
   output logic                 mem_ld_go_o,
   output logic                 mem_st_go_o,
   output vcore_pkg::addr_t     mem_base_o,
   output vcore_pkg::vl_t       vl_o,
   output logic                 alu_we_o,
   output vcore_pkg::alu_op_e   alu_op_o,
   output vcore_pkg::vreg_idx_t vd_o,
   output vcore_pkg::vreg_idx_t vs1_o,
   output vcore_pkg::vreg_idx_t vs2_o,
   output vcore_pkg::elem_t     scalar_o,
   output logic                 use_scalar_o
   );
   import vcore_pkg::*;

   ctrl_state_e state;
   vreg_idx_t   vd_q;
   vl_t         vl_q;
   logic [6:0]  opcode;
   logic [2:0]  funct3;  // Also the width field of loads and stores
   logic [5:0]  funct6;
   logic        f6_known;
   logic        accept;
   logic        is_cfg;
   logic        is_arith;
   logic        is_ld;
   logic        is_st;

   assign opcode = vector_instr_i[6:0];
   assign funct3 = vector_instr_i[14:12];
   assign funct6 = vector_instr_i[31:26];

   assign vector_stall_o = (state == CTRL_MEM);
   assign accept         = vector_instr_vld_i && !vector_stall_o;

   always_comb
   begin
      alu_op_o = ALU_ADD;
      f6_known = 1'b1;
      case (funct6)
         F6_VADD: alu_op_o = ALU_ADD;
         F6_VSUB: alu_op_o = ALU_SUB;
         F6_VAND: alu_op_o = ALU_AND;
         F6_VOR:  alu_op_o = ALU_OR;
         F6_VXOR: alu_op_o = ALU_XOR;
         default: f6_known = 1'b0;
      endcase
   end

   // vsetvli only, bit 31 set would be vsetvl
   assign is_cfg   = (opcode == OPC_OPV) && (funct3 == F3_OPCFG) && !vector_instr_i[31];
   assign is_arith = (opcode == OPC_OPV) && f6_known &&
                     ((funct3 == F3_OPIVV) || (funct3 == F3_OPIVX));
   assign is_ld    = (opcode == OPC_LOAD_FP) && (funct3 == MEM_W32);
   assign is_st    = (opcode == OPC_STORE_FP) && (funct3 == MEM_W32);

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         state       <= CTRL_IDLE;
         vl_q        <= '0;
         mem_ld_go_o <= 1'b0;
         mem_st_go_o <= 1'b0;
      end
      else
      begin
         mem_ld_go_o <= accept && is_ld;
         mem_st_go_o <= accept && is_st;
         if (accept && is_cfg)
            vl_q <= (rs1_i > elem_t'(VLMAX)) ? vl_t'(VLMAX) : vl_t'(rs1_i);
         case (state)
            CTRL_IDLE:
               if (accept && (is_ld || is_st))
                  state <= CTRL_MEM;
            CTRL_MEM:
               if (mem_done_i)
                  state <= CTRL_IDLE;
            default:
               state <= CTRL_IDLE;
         endcase
      end
   end

   // Register and base captured when a transfer is accepted
   always_ff @(posedge clk)
   begin
      if (accept && (is_ld || is_st))
      begin
         vd_q       <= vector_instr_i[11:7];  // vs3 for stores
         mem_base_o <= rs1_i;
      end
   end

   assign vl_o         = vl_q;
   assign alu_we_o     = accept && is_arith;  // Written at the accepting edge
   assign vd_o         = (state == CTRL_MEM) ? vd_q : vector_instr_i[11:7];
   assign vs1_o        = vector_instr_i[19:15];
   assign vs2_o        = vector_instr_i[24:20];
   assign scalar_o     = rs1_i;
   assign use_scalar_o = (funct3 == F3_OPIVX);

endmodule

// ==== logic/vcore_pkg.sv ====
package vcore_pkg;

   localparam int LANE_NUM   = 4;
   localparam int VREG_NUM   = 32;
   localparam int ELEM_BYTES = 4;
   localparam int VLMAX      = LANE_NUM;  // SEW 32, LMUL 1

   // RVV major opcodes
   localparam logic [6:0] OPC_OPV      = 7'b1010111;
   localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
   localparam logic [6:0] OPC_STORE_FP = 7'b0100111;

   localparam logic [2:0] F3_OPIVV = 3'b000;
   localparam logic [2:0] F3_OPIVX = 3'b100;
   localparam logic [2:0] F3_OPCFG = 3'b111;

   localparam logic [5:0] F6_VADD = 6'b000000;
   localparam logic [5:0] F6_VSUB = 6'b000010;
   localparam logic [5:0] F6_VAND = 6'b001001;
   localparam logic [5:0] F6_VOR  = 6'b001010;
   localparam logic [5:0] F6_VXOR = 6'b001011;

   localparam logic [2:0] MEM_W32 = 3'b110;  // Width field of vle32/vse32

   typedef logic [31:0] elem_t;
   typedef logic [31:0] addr_t;
   typedef logic [31:0] xfer_size_t;
   typedef logic [4:0]  vreg_idx_t;
   typedef logic [1:0]  elem_idx_t;
   typedef logic [2:0]  vl_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_e;

   typedef enum logic {
      CTRL_IDLE,
      CTRL_MEM
   } ctrl_state_e;

   typedef enum logic [1:0] {
      MEM_IDLE,
      MEM_START,
      MEM_STREAM,
      MEM_WAIT
   } mem_state_e;

endpackage
